// ==== source/exec_isa_pkg.sv ====
package exec_isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // instruction word fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int INST_W   = 32;
  localparam int OPCODE_W = 7;
  localparam int FUNCT3_W = 3;
  localparam int FUNCT7_W = 7;

  typedef logic [INST_W-1:0]   inst_t;
  typedef logic [OPCODE_W-1:0] opcode_t;
  typedef logic [FUNCT3_W-1:0] funct3_t;
  typedef logic [FUNCT7_W-1:0] funct7_t;

  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_IMM_32 = 7'b0011011;
  localparam opcode_t OPC_OP_32  = 7'b0111011;

  // physical register index, entry 0 is the hard zero
  typedef logic [5:0] preg_idx_t;
  typedef logic [3:0] tag_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decoded control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [3:0] {
    OP_NONE, OP_LUI, OP_AUIPC,
    OP_ADD, OP_SUB, OP_XOR, OP_OR, OP_AND,
    OP_SLL, OP_SRL, OP_SRA,
    OP_ADDW, OP_SLLW, OP_SRLW, OP_SRAW
  } alu_op_t;

  // IMM_U replaces rs2 with the upper immediate for LUI and AUIPC
  typedef enum logic [1:0] {
    IMM_NONE,
    IMM_I,
    IMM_SH,
    IMM_U
  } imm_kind_t;

endpackage

// ==== source/exec_bus_pkg.sv ====
package exec_bus_pkg;

  // data fields are sized for the widest XLEN, narrower builds use the low bits
  localparam int DATA_W     = 64;
  localparam int APB_ADDR_W = 10;
  localparam int APB_DATA_W = 32;

  typedef logic [DATA_W-1:0]     data_t;
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // issue into the ALU pipe
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic                    valid;
    exec_isa_pkg::inst_t     inst;
    data_t                   pc;
    logic                    rs1_valid;
    exec_isa_pkg::preg_idx_t rs1;
    logic                    rs2_valid;
    exec_isa_pkg::preg_idx_t rs2;
    logic                    rd_valid;
    exec_isa_pkg::preg_idx_t rd;
    exec_isa_pkg::tag_t      tag;
  } issue_t;

  // physical register write, also used as the forwarding bus
  typedef struct packed {
    logic                    valid;
    exec_isa_pkg::preg_idx_t rd;
    data_t                   data;
  } preg_wr_t;

  // completion record
  typedef struct packed {
    logic               valid;
    exec_isa_pkg::tag_t tag;
    data_t              result;
  } done_t;

endpackage

// ==== source/alu_inst_decoder.sv ====
module alu_inst_decoder #(
  parameter int XLEN = 64
) (
  input  exec_isa_pkg::inst_t     i_inst,
  output exec_isa_pkg::alu_op_t   o_op,
  output exec_isa_pkg::imm_kind_t o_imm_kind
);

  exec_isa_pkg::opcode_t w_opcode;
  exec_isa_pkg::funct3_t w_funct3;
  exec_isa_pkg::funct7_t w_funct7;
  logic                  w_f7_zero;
  logic                  w_f7_alt;
  logic                  w_sh_zero;
  logic                  w_sh_alt;

  assign w_opcode  = i_inst[6:0];
  assign w_funct3  = i_inst[14:12];
  assign w_funct7  = i_inst[31:25];
  assign w_f7_zero = (w_funct7 == 7'b0000000);
  assign w_f7_alt  = (w_funct7 == 7'b0100000);
  // shift immediates may use bit 25 as shamt[5] only at XLEN 64
  assign w_sh_zero = (i_inst[31:26] == 6'b000000) && ((XLEN == 64) || !i_inst[25]);
  assign w_sh_alt  = (i_inst[31:26] == 6'b010000) && ((XLEN == 64) || !i_inst[25]);

  always_comb begin
    o_op       = exec_isa_pkg::OP_NONE;
    o_imm_kind = exec_isa_pkg::IMM_NONE;
    case (w_opcode)
      exec_isa_pkg::OPC_LUI: begin
        o_op       = exec_isa_pkg::OP_LUI;
        o_imm_kind = exec_isa_pkg::IMM_U;
      end
      exec_isa_pkg::OPC_AUIPC: begin
        o_op       = exec_isa_pkg::OP_AUIPC;
        o_imm_kind = exec_isa_pkg::IMM_U;
      end
      exec_isa_pkg::OPC_OP_IMM: begin
        o_imm_kind = exec_isa_pkg::IMM_I;
        case (w_funct3)
          3'b000: o_op = exec_isa_pkg::OP_ADD;
          3'b100: o_op = exec_isa_pkg::OP_XOR;
          3'b110: o_op = exec_isa_pkg::OP_OR;
          3'b111: o_op = exec_isa_pkg::OP_AND;
          3'b001: begin
            o_imm_kind = exec_isa_pkg::IMM_SH;
            if (w_sh_zero) o_op = exec_isa_pkg::OP_SLL;
          end
          3'b101: begin
            o_imm_kind = exec_isa_pkg::IMM_SH;
            if (w_sh_zero) o_op = exec_isa_pkg::OP_SRL;
            else if (w_sh_alt) o_op = exec_isa_pkg::OP_SRA;
          end
          default: o_op = exec_isa_pkg::OP_NONE;
        endcase
      end
      exec_isa_pkg::OPC_OP: begin
        if (w_f7_zero) begin
          case (w_funct3)
            3'b000:  o_op = exec_isa_pkg::OP_ADD;
            3'b001:  o_op = exec_isa_pkg::OP_SLL;
            3'b100:  o_op = exec_isa_pkg::OP_XOR;
            3'b101:  o_op = exec_isa_pkg::OP_SRL;
            3'b110:  o_op = exec_isa_pkg::OP_OR;
            3'b111:  o_op = exec_isa_pkg::OP_AND;
            default: o_op = exec_isa_pkg::OP_NONE;
          endcase
        end else if (w_f7_alt && w_funct3 == 3'b000) begin
          o_op = exec_isa_pkg::OP_SUB;
        end else if (w_f7_alt && w_funct3 == 3'b101) begin
          o_op = exec_isa_pkg::OP_SRA;
        end
      end
      // word forms exist only on a 64-bit datapath
      exec_isa_pkg::OPC_IMM_32: begin
        o_imm_kind = exec_isa_pkg::IMM_I;
        if (XLEN == 64 && w_funct3 == 3'b000) o_op = exec_isa_pkg::OP_ADDW;
      end
      exec_isa_pkg::OPC_OP_32: begin
        if (XLEN == 64 && w_f7_zero) begin
          case (w_funct3)
            3'b000:  o_op = exec_isa_pkg::OP_ADDW;
            3'b001:  o_op = exec_isa_pkg::OP_SLLW;
            3'b101:  o_op = exec_isa_pkg::OP_SRLW;
            default: o_op = exec_isa_pkg::OP_NONE;
          endcase
        end else if (XLEN == 64 && w_f7_alt && w_funct3 == 3'b101) begin
          o_op = exec_isa_pkg::OP_SRAW;
        end
      end
      default: o_op = exec_isa_pkg::OP_NONE;
    endcase
  end

endmodule

// ==== source/phys_regfile.sv ====
module phys_regfile #(
  parameter int XLEN      = 64,
  parameter int NUM_PREGS = 64
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  exec_isa_pkg::preg_idx_t i_rd_idx0,
  input  exec_isa_pkg::preg_idx_t i_rd_idx1,
  output exec_bus_pkg::data_t     o_rd_data0,
  output exec_bus_pkg::data_t     o_rd_data1,
  input  exec_bus_pkg::preg_wr_t  i_wr,
  input  logic                    i_apb_en,
  input  logic                    i_apb_write,
  input  exec_isa_pkg::preg_idx_t i_apb_idx,
  input  logic                    i_apb_half,
  input  exec_bus_pkg::apb_data_t i_apb_wdata,
  output exec_bus_pkg::apb_data_t o_apb_rdata,
  output logic                    o_apb_busy
);

  logic [XLEN-1:0]     r_regs [NUM_PREGS];
  exec_bus_pkg::data_t w_apb_word;
  exec_bus_pkg::data_t w_apb_merged;

  // combinational read with write-through of the pipe write in this cycle
  function automatic logic [XLEN-1:0] read_preg(input exec_isa_pkg::preg_idx_t idx);
    logic [XLEN-1:0] val;
    val = '0;
    if (idx != '0 && int'(idx) < NUM_PREGS) begin
      if (i_wr.valid && i_wr.rd == idx) begin
        val = i_wr.data[XLEN-1:0];
      end else begin
        val = r_regs[idx];
      end
    end
    return val;
  endfunction

  assign o_rd_data0 = exec_bus_pkg::data_t'(read_preg(i_rd_idx0));
  assign o_rd_data1 = exec_bus_pkg::data_t'(read_preg(i_rd_idx1));

  // the APB side sees one 32-bit half of a 64-bit view of the entry
  assign w_apb_word  = exec_bus_pkg::data_t'(read_preg(i_apb_idx));
  assign o_apb_rdata = i_apb_half ? w_apb_word[63:32] : w_apb_word[31:0];
  assign o_apb_busy  = i_wr.valid;

  always_comb begin
    w_apb_merged = w_apb_word;
    if (i_apb_half) w_apb_merged[63:32] = i_apb_wdata;
    else w_apb_merged[31:0] = i_apb_wdata;
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < NUM_PREGS; i++) r_regs[i] <= '0;
    end else if (i_wr.valid) begin
      if (i_wr.rd != '0 && int'(i_wr.rd) < NUM_PREGS) r_regs[i_wr.rd] <= i_wr.data[XLEN-1:0];
    end else if (i_apb_en && i_apb_write && i_apb_idx != '0) begin
      r_regs[i_apb_idx] <= w_apb_merged[XLEN-1:0];
    end
  end

endmodule

// ==== source/apb_preg_port.sv ====
module apb_preg_port #(
  parameter int XLEN      = 64,
  parameter int NUM_PREGS = 64
) (
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  exec_bus_pkg::apb_addr_t i_paddr,
  input  exec_bus_pkg::apb_data_t i_pwdata,
  output exec_bus_pkg::apb_data_t o_prdata,
  output logic                    o_pready,
  output logic                    o_pslverr,
  output logic                    o_apb_en,
  output logic                    o_apb_write,
  output exec_isa_pkg::preg_idx_t o_apb_idx,
  output logic                    o_apb_half,
  output exec_bus_pkg::apb_data_t o_apb_wdata,
  input  exec_bus_pkg::apb_data_t i_apb_rdata,
  input  logic                    i_apb_busy
);

  logic [6:0] w_idx_field;
  logic       w_access;
  logic       w_bad_addr;
  logic       w_stall;

  // paddr[9:3] is the register index, paddr[2] picks the upper half
  assign w_idx_field = i_paddr[9:3];
  assign w_bad_addr  = (int'(w_idx_field) >= NUM_PREGS) || (i_paddr[2] && XLEN == 32);
  assign w_access    = i_psel && i_penable;

  // a write waits while the pipe owns the write port; the master holds
  // the access phase, so the request stays up until it lands
  assign w_stall = w_access && i_pwrite && !w_bad_addr && i_apb_busy;

  assign o_pready  = !w_stall;
  assign o_pslverr = w_access && w_bad_addr;
  assign o_prdata  = (w_access && !w_bad_addr && !i_pwrite) ? i_apb_rdata : '0;

  assign o_apb_en    = w_access && !w_bad_addr;
  assign o_apb_write = i_pwrite;
  assign o_apb_idx   = exec_isa_pkg::preg_idx_t'(w_idx_field);
  assign o_apb_half  = i_paddr[2];
  assign o_apb_wdata = i_pwdata;

endmodule

// ==== source/alu_exec_pipe.sv ====
module alu_exec_pipe #(
  parameter int XLEN      = 64,
  parameter int NUM_PREGS = 64
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  exec_bus_pkg::issue_t    i_issue,
  output exec_isa_pkg::preg_idx_t o_rd_idx0,
  output exec_isa_pkg::preg_idx_t o_rd_idx1,
  input  exec_bus_pkg::data_t     i_rd_data0,
  input  exec_bus_pkg::data_t     i_rd_data1,
  output exec_bus_pkg::preg_wr_t  o_wr,
  output exec_bus_pkg::done_t     o_done
);

  localparam int SHW = $clog2(XLEN);

  typedef struct packed {
    exec_isa_pkg::alu_op_t   op;
    exec_isa_pkg::imm_kind_t imm;
  } ctrl_t;

  ctrl_t                w_ex0_ctrl;
  exec_bus_pkg::issue_t r_ex1_issue;
  ctrl_t                r_ex1_ctrl;
  exec_bus_pkg::issue_t r_ex2_issue;
  ctrl_t                r_ex2_ctrl;
  logic [XLEN-1:0]      r_ex2_rs1;
  logic [XLEN-1:0]      r_ex2_rs2;
  exec_bus_pkg::issue_t r_ex3_issue;
  logic [XLEN-1:0]      r_ex3_result;

  exec_bus_pkg::data_t  w_imm_i;
  exec_bus_pkg::data_t  w_imm_u;
  logic [XLEN-1:0]      w_imm_sh;
  logic                 w_fwd_rs1;
  logic                 w_fwd_rs2;
  logic [XLEN-1:0]      w_a;
  logic [XLEN-1:0]      w_b;
  logic [31:0]          w_res32;
  exec_bus_pkg::data_t  w_res32_sext;
  logic [XLEN-1:0]      w_result;

  alu_inst_decoder #(
    .XLEN (XLEN)
  ) alu_inst_decoder_inst (
    .i_inst     (i_issue.inst),
    .o_op       (w_ex0_ctrl.op),
    .o_imm_kind (w_ex0_ctrl.imm)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ex1: capture issue and decode, read the sources
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
    end else begin
      r_ex1_issue <= i_issue;
      r_ex1_ctrl  <= w_ex0_ctrl;
    end
  end

  // an unused source reads index 0, which returns zero
  assign o_rd_idx0 = r_ex1_issue.rs1_valid ? r_ex1_issue.rs1 : '0;
  assign o_rd_idx1 = r_ex1_issue.rs2_valid ? r_ex1_issue.rs2 : '0;

  assign w_imm_i = {{52{r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:20]};
  assign w_imm_u = {{32{r_ex1_issue.inst[31]}}, r_ex1_issue.inst[31:12], 12'h000};

  always_comb begin
    w_imm_sh = '0;
    w_imm_sh[SHW-1:0] = r_ex1_issue.inst[20 +: SHW];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ex2: operands, forwarding from ex3, compute
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_issue <= '0;
      r_ex2_ctrl  <= '0;
    end else begin
      r_ex2_issue <= r_ex1_issue;
      r_ex2_ctrl  <= r_ex1_ctrl;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex2_rs1 <= i_rd_data0[XLEN-1:0];
    case (r_ex1_ctrl.imm)
      exec_isa_pkg::IMM_I:  r_ex2_rs2 <= w_imm_i[XLEN-1:0];
      exec_isa_pkg::IMM_SH: r_ex2_rs2 <= w_imm_sh;
      exec_isa_pkg::IMM_U:  r_ex2_rs2 <= w_imm_u[XLEN-1:0];
      default:              r_ex2_rs2 <= i_rd_data1[XLEN-1:0];
    endcase
  end

  // the ex3 write is the only forwarding source; x0 never forwards
  assign w_fwd_rs1 = r_ex2_issue.rs1_valid && o_wr.valid &&
                     (o_wr.rd == r_ex2_issue.rs1) && (r_ex2_issue.rs1 != '0);
  assign w_fwd_rs2 = r_ex2_issue.rs2_valid && o_wr.valid &&
                     (r_ex2_ctrl.imm == exec_isa_pkg::IMM_NONE) &&
                     (o_wr.rd == r_ex2_issue.rs2) && (r_ex2_issue.rs2 != '0);

  assign w_a = w_fwd_rs1 ? o_wr.data[XLEN-1:0] : r_ex2_rs1;
  assign w_b = w_fwd_rs2 ? o_wr.data[XLEN-1:0] : r_ex2_rs2;

  always_comb begin
    case (r_ex2_ctrl.op)
      exec_isa_pkg::OP_SLLW: w_res32 = w_a[31:0] << w_b[4:0];
      exec_isa_pkg::OP_SRLW: w_res32 = w_a[31:0] >> w_b[4:0];
      exec_isa_pkg::OP_SRAW: w_res32 = $signed(w_a[31:0]) >>> w_b[4:0];
      default:               w_res32 = w_a[31:0] + w_b[31:0];
    endcase
  end

  assign w_res32_sext = {{32{w_res32[31]}}, w_res32};

  always_comb begin
    case (r_ex2_ctrl.op)
      exec_isa_pkg::OP_LUI:   w_result = w_b;
      exec_isa_pkg::OP_AUIPC: w_result = r_ex2_issue.pc[XLEN-1:0] + w_b;
      exec_isa_pkg::OP_ADD:   w_result = w_a + w_b;
      exec_isa_pkg::OP_SUB:   w_result = w_a - w_b;
      exec_isa_pkg::OP_XOR:   w_result = w_a ^ w_b;
      exec_isa_pkg::OP_OR:    w_result = w_a | w_b;
      exec_isa_pkg::OP_AND:   w_result = w_a & w_b;
      exec_isa_pkg::OP_SLL:   w_result = w_a << w_b[SHW-1:0];
      exec_isa_pkg::OP_SRL:   w_result = w_a >> w_b[SHW-1:0];
      exec_isa_pkg::OP_SRA:   w_result = $signed(w_a) >>> w_b[SHW-1:0];
      exec_isa_pkg::OP_ADDW, exec_isa_pkg::OP_SLLW,
      exec_isa_pkg::OP_SRLW, exec_isa_pkg::OP_SRAW:
        w_result = w_res32_sext[XLEN-1:0];
      default:                w_result = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ex3: writeback and completion
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_issue <= '0;
    end else begin
      r_ex3_issue <= r_ex2_issue;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_result <= w_result;
  end

  assign o_wr.valid = r_ex3_issue.valid && r_ex3_issue.rd_valid;
  assign o_wr.rd    = r_ex3_issue.rd;
  assign o_wr.data  = exec_bus_pkg::data_t'(r_ex3_result);

  assign o_done.valid  = r_ex3_issue.valid;
  assign o_done.tag    = r_ex3_issue.tag;
  assign o_done.result = exec_bus_pkg::data_t'(r_ex3_result);

endmodule

// ==== source/alu_exec_top.sv ====
module alu_exec_top #(
  parameter int XLEN      = 64,
  parameter int NUM_PREGS = 64
) (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  exec_bus_pkg::apb_addr_t i_paddr,
  input  exec_bus_pkg::apb_data_t i_pwdata,
  output exec_bus_pkg::apb_data_t o_prdata,
  output logic                    o_pready,
  output logic                    o_pslverr,
  input  exec_bus_pkg::issue_t    i_issue,
  output exec_bus_pkg::done_t     o_done
);

  logic                    w_apb_en;
  logic                    w_apb_write;
  exec_isa_pkg::preg_idx_t w_apb_idx;
  logic                    w_apb_half;
  exec_bus_pkg::apb_data_t w_apb_wdata;
  exec_bus_pkg::apb_data_t w_apb_rdata;
  logic                    w_apb_busy;
  exec_isa_pkg::preg_idx_t w_rd_idx0;
  exec_isa_pkg::preg_idx_t w_rd_idx1;
  exec_bus_pkg::data_t     w_rd_data0;
  exec_bus_pkg::data_t     w_rd_data1;
  exec_bus_pkg::preg_wr_t  w_wr;

  apb_preg_port #(
    .XLEN      (XLEN),
    .NUM_PREGS (NUM_PREGS)
  ) apb_preg_port_inst (
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_apb_en    (w_apb_en),
    .o_apb_write (w_apb_write),
    .o_apb_idx   (w_apb_idx),
    .o_apb_half  (w_apb_half),
    .o_apb_wdata (w_apb_wdata),
    .i_apb_rdata (w_apb_rdata),
    .i_apb_busy  (w_apb_busy)
  );

  phys_regfile #(
    .XLEN      (XLEN),
    .NUM_PREGS (NUM_PREGS)
  ) phys_regfile_inst (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_rd_idx0   (w_rd_idx0),
    .i_rd_idx1   (w_rd_idx1),
    .o_rd_data0  (w_rd_data0),
    .o_rd_data1  (w_rd_data1),
    .i_wr        (w_wr),
    .i_apb_en    (w_apb_en),
    .i_apb_write (w_apb_write),
    .i_apb_idx   (w_apb_idx),
    .i_apb_half  (w_apb_half),
    .i_apb_wdata (w_apb_wdata),
    .o_apb_rdata (w_apb_rdata),
    .o_apb_busy  (w_apb_busy)
  );

  alu_exec_pipe #(
    .XLEN      (XLEN),
    .NUM_PREGS (NUM_PREGS)
  ) alu_exec_pipe_inst (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_issue    (i_issue),
    .o_rd_idx0  (w_rd_idx0),
    .o_rd_idx1  (w_rd_idx1),
    .i_rd_data0 (w_rd_data0),
    .i_rd_data1 (w_rd_data1),
    .o_wr       (w_wr),
    .o_done     (o_done)
  );

endmodule

// ==== dv/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD = 100
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // reset stays low for two rising edges and is released on a falling edge
  initial begin
    o_reset_n = 1'b0;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

// ==== dv/alu_exec_assertions.sv ====
module alu_exec_assertions (
  input logic i_clk,
  input logic i_reset_n,
  input logic i_psel,
  input logic i_penable,
  input logic i_pwrite,
  input logic i_pready,
  input logic i_issue_valid,
  input logic i_done_valid
);

  // no completion may be reported while the core is held in reset
  done_low_in_reset: assert property (
    @(posedge i_clk) !i_reset_n |-> !i_done_valid
  ) else $error("completion valid while in reset");

  // reads never wait, only writes can be held off by the pipe
  read_never_waits: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      (i_psel && i_penable && !i_pwrite) |-> i_pready
  ) else $error("APB read access was held off");

  issue_to_done: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
      i_issue_valid |-> ##3 i_done_valid
  ) else $error("issue did not complete three cycles later");

endmodule

// ==== dv/alu_exec_tb.sv ====
module alu_exec_tb;

  localparam int TIMEOUT_CYCLES = 50;

  logic                    clk;
  logic                    reset_n;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  exec_bus_pkg::apb_addr_t paddr;
  exec_bus_pkg::apb_data_t pwdata;
  exec_bus_pkg::apb_data_t prdata;
  logic                    pready;
  logic                    pslverr;
  exec_bus_pkg::issue_t    issue;
  exec_bus_pkg::done_t     done;

  int          mismatch_errors;
  int          other_errors;
  longint      cycle_cnt;
  logic [7:0]  lfsr_state;
  logic [3:0]  exp_tag [$];
  logic [63:0] exp_result [$];
  longint      exp_due [$];

  tb_clock_gen clock_gen_inst (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  alu_exec_top #(
    .XLEN      (64),
    .NUM_PREGS (64)
  ) alu_exec_top_inst (
    .i_clk     (clk),
    .i_reset_n (reset_n),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr),
    .i_issue   (issue),
    .o_done    (done)
  );

  bind alu_exec_top alu_exec_assertions alu_exec_assertions_inst (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_pready      (o_pready),
    .i_issue_valid (i_issue.valid),
    .i_done_valid  (o_done.valid)
  );

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
  end

  // Galois LFSR, x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] state);
    logic [7:0] next;
    next = state >> 1;
    if (state[0]) next = next ^ 8'hb8;
    return next;
  endfunction

  task automatic drive_idle();
    issue   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      drive_idle();
    end
  endtask

  // two LFSR bits give 0 to 3 idle cycles
  task automatic random_idle();
    int n;
    n = 0;
    for (int b = 0; b < 2; b++) begin
      n = (n << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    idle_cycles(n);
  endtask

  task automatic issue_inst(input logic [63:0] f [10]);
    @(negedge clk);
    drive_idle();
    issue.valid     = 1'b1;
    issue.inst      = f[0][31:0];
    issue.pc        = f[1];
    issue.rs1_valid = f[2][0];
    issue.rs1       = f[3][5:0];
    issue.rs2_valid = f[4][0];
    issue.rs2       = f[5][5:0];
    issue.rd_valid  = f[6][0];
    issue.rd        = f[7][5:0];
    issue.tag       = f[8][3:0];
    exp_tag.push_back(f[8][3:0]);
    exp_result.push_back(f[9]);
    exp_due.push_back(cycle_cnt + 3);
  endtask

  task automatic apb_access(input logic write, input logic [6:0] idx, input logic half,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err, output int waits);
    @(negedge clk);
    drive_idle();
    psel   = 1'b1;
    pwrite = write;
    paddr  = {idx, half, 2'b00};
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits = 0;
    #10;
    while (!pready && waits < TIMEOUT_CYCLES) begin
      waits++;
      @(negedge clk);
      #10;
    end
    assert (pready) else begin
      other_errors++;
      $display("APB transfer to register %h never completed", idx);
    end
    rdata = prdata;
    err   = pslverr;
  endtask

  task automatic drain_completions();
    int guard;
    guard = 0;
    while (exp_tag.size() != 0 && guard < TIMEOUT_CYCLES) begin
      @(negedge clk);
      drive_idle();
      guard++;
    end
    assert (exp_tag.size() == 0) else begin
      other_errors++;
      $display("%0d completions never arrived", exp_tag.size());
      exp_tag.delete();
      exp_result.delete();
      exp_due.delete();
    end
  endtask

  // o_done only changes on a rising edge, so the falling edge sees it settled
  always @(negedge clk) begin
    if (reset_n) begin
      if (done.valid) begin
        assert (exp_tag.size() != 0) else begin
          other_errors++;
          $display("completion with tag %h arrived with nothing outstanding", done.tag);
        end
        if (exp_tag.size() != 0) begin
          assert (done.tag == exp_tag[0]) else begin
            mismatch_errors++;
            $display("Mismatch o_done.tag: expected %h, got %h", exp_tag[0], done.tag);
          end
          assert (done.result == exp_result[0]) else begin
            mismatch_errors++;
            $display("Mismatch o_done.result: expected %h, got %h",
                     exp_result[0], done.result);
          end
          assert (cycle_cnt == exp_due[0]) else begin
            mismatch_errors++;
            $display("Mismatch o_done cycle: expected %h, got %h", exp_due[0], cycle_cnt);
          end
          void'(exp_tag.pop_front());
          void'(exp_result.pop_front());
          void'(exp_due.pop_front());
        end
      end else if (exp_due.size() != 0 && exp_due[0] < cycle_cnt) begin
        assert (0) else begin
          other_errors++;
          $display("completion with tag %h did not arrive in time", exp_tag[0]);
        end
        void'(exp_tag.pop_front());
        void'(exp_result.pop_front());
        void'(exp_due.pop_front());
      end
    end
  end

  initial begin
    int          fd;
    int          n;
    int          guard;
    int          waits;
    string       line;
    logic [7:0]  kind;
    logic [63:0] f [10];
    logic [31:0] rdata;
    logic        err;
    logic        after_apb;

    drive_idle();
    mismatch_errors = 0;
    other_errors    = 0;
    cycle_cnt       = 0;
    lfsr_state      = 8'd25;
    after_apb       = 1'b0;

    fd = $fopen("dv/alu_exec_testdata.txt", "r");
    assert (fd != 0) else begin
      other_errors++;
      $display("could not open the test data file");
    end

    guard = 0;
    while (!reset_n && guard < TIMEOUT_CYCLES) begin
      @(negedge clk);
      guard++;
    end
    assert (reset_n) else begin
      other_errors++;
      $display("reset was never released");
    end

    while (fd != 0 && !$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        kind = line.getc(0);
        case (kind)
          "P": begin
            n = $sscanf(line, "%c %h %h %h %h %h", kind, f[0], f[1], f[2], f[3], f[4]);
            apb_access(1'b1, f[0][6:0], f[1][0], f[2][31:0], rdata, err, waits);
            assert (err == f[3][0]) else begin
              mismatch_errors++;
              $display("Mismatch o_pslverr: expected %h, got %h", f[3][0], err);
            end
            assert (waits == int'(f[4])) else begin
              mismatch_errors++;
              $display("Mismatch o_pready wait cycles: expected %h, got %h", f[4], waits);
            end
            after_apb = 1'b1;
          end
          "R": begin
            n = $sscanf(line, "%c %h %h %h %h", kind, f[0], f[1], f[2], f[3]);
            drain_completions();
            apb_access(1'b0, f[0][6:0], f[1][0], 32'h0, rdata, err, waits);
            assert (rdata == f[2][31:0]) else begin
              mismatch_errors++;
              $display("Mismatch o_prdata: expected %h, got %h", f[2][31:0], rdata);
            end
            assert (err == f[3][0]) else begin
              mismatch_errors++;
              $display("Mismatch o_pslverr: expected %h, got %h", f[3][0], err);
            end
            after_apb = 1'b1;
          end
          "I": begin
            n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h", kind, f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
            if (after_apb) random_idle();
            after_apb = 1'b0;
            issue_inst(f);
          end
          "G": begin
            n = $sscanf(line, "%c %h", kind, f[0]);
            idle_cycles(int'(f[0]));
          end
          default: begin
            assert (0) else begin
              other_errors++;
              $display("unknown record in test data: %s", line);
            end
          end
        endcase
      end
    end
    if (fd != 0) $fclose(fd);

    drain_completions();
    idle_cycles(4);

    $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== dv/alu_exec_testdata.txt ====
# P idx half wdata err waits | R idx half expected err | G idle_cycles
# I inst pc rs1v rs1 rs2v rs2 rdv rd tag expected (all fields hex)
P 01 0 00000007 0 0
P 02 0 00000003 0 0
P 03 0 00000001 0 0
P 03 1 80000000 0 0
P 04 0 7fffffff 0 0
P 05 0 fffffff0 0 0
P 05 1 ffffffff 0 0
P 06 0 0000003f 0 0
P 07 0 11111111 0 0
P 07 1 22222222 0 0
P 40 0 deadbeef 1 0
R 07 0 11111111 0
R 07 1 22222222 0
R 03 1 80000000 0
R 40 0 00000000 1
I 00000033 0 1 01 1 02 1 0a 1 000000000000000a
I 40000033 0 1 02 1 01 1 0b 2 fffffffffffffffc
I 00004033 0 1 01 1 02 1 0c 3 0000000000000004
I 00006033 0 1 01 1 05 1 0d 4 fffffffffffffff7
I 00007033 0 1 05 1 01 1 0e 5 0000000000000000
I 00001033 0 1 01 1 06 1 0f 6 8000000000000000
I 00005033 0 1 03 1 06 1 10 7 0000000000000001
I 40005033 0 1 03 1 06 1 11 8 ffffffffffffffff
I ffb00013 0 1 01 0 00 1 12 9 0000000000000002
I fff04013 0 1 01 0 00 1 13 a fffffffffffffff8
I 0f006013 0 1 02 0 00 1 14 b 00000000000000f3
I ff007013 0 1 05 0 00 1 15 c fffffffffffffff0
I 03f01013 0 1 01 0 00 1 16 d 8000000000000000
I 00005013 0 1 03 0 00 1 17 e 8000000000000001
I 43f05013 0 1 03 0 00 1 18 f ffffffffffffffff
I 80000037 0 0 00 0 00 1 19 0 ffffffff80000000
I 00001017 1000 0 00 0 00 1 1a 1 0000000000002000
I 0000003b 0 1 04 1 01 1 1b 2 ffffffff80000006
I 0010001b 0 1 04 0 00 1 1c 3 ffffffff80000000
I 0000103b 0 1 04 1 02 1 1d 4 fffffffffffffff8
I 0000503b 0 1 05 1 02 1 1e 5 000000001ffffffe
I 4000503b 0 1 05 1 02 1 1f 6 fffffffffffffffe
I 00100013 0 1 01 0 00 1 28 7 0000000000000008
I 00000033 0 1 28 1 28 1 29 8 0000000000000010
G 1
I 00000033 0 1 29 1 02 1 2a 9 0000000000000013
G 2
I 00000033 0 1 2a 1 01 1 2b a 000000000000001a
I 12300013 0 0 00 0 00 1 00 b 0000000000000123
I 00000033 0 1 00 1 01 1 2c c 0000000000000007
G 1
I 00000033 0 1 00 1 02 1 2d d 0000000000000003
R 0f 1 80000000 0
R 1b 0 80000006 0
R 1b 1 ffffffff 0
R 2b 0 0000001a 0
R 00 0 00000000 0
I 01000013 0 1 01 0 00 1 32 e 0000000000000017
G 1
P 33 0 cafe0001 0 1
R 32 0 00000017 0
R 33 0 cafe0001 0
P 34 0 0badf00d 0 0
R 34 0 0badf00d 0
I 00000013 0 1 02 0 00 1 34 f 0000000000000003
R 34 0 00000003 0
R 34 1 00000000 0

// ==== filelist.f ====
source/exec_isa_pkg.sv
source/exec_bus_pkg.sv
source/alu_inst_decoder.sv
source/phys_regfile.sv
source/apb_preg_port.sv
source/alu_exec_pipe.sv
source/alu_exec_top.sv
dv/tb_clock_gen.sv
dv/alu_exec_assertions.sv
dv/alu_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= alu_exec_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
